// File: Makefile
# Verilator build and run for the vector lane testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_lane
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: lane_decode.sv
// Issue stage that registers a command and produces read addresses and execute control
module lane_decode (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  cmd_valid_i,
    input  lane_pkg::lane_cmd_t                   cmd_i,
    output logic [lane_pkg::vreg_addr_w-1:0]      raddr_a_o,
    output logic [lane_pkg::vreg_addr_w-1:0]      raddr_b_o,
    output lane_pkg::exec_ctrl_t                  exec_ctrl_o
);

    lane_pkg::lane_cmd_t  cmd_q;
    logic                 cmd_valid_q;
    lane_pkg::exec_ctrl_t exec_next;

    //////////////////////////////////////////////////
    // Issue register, sampled at E0
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid_i;
        end
        cmd_q <= cmd_i;
    end

    // Register file samples these at E1
    assign raddr_a_o = cmd_q.vs1;
    assign raddr_b_o = cmd_q.vs2;

    always_comb begin
        exec_next.el_idx     = cmd_q.el_idx;
        exec_next.op2_sel    = cmd_q.op2_sel;
        exec_next.scalar     = cmd_q.scalar;
        exec_next.imm        = {{(lane_pkg::word_w - lane_pkg::imm_w){1'b0}}, cmd_q.imm};
        exec_next.alu_op     = cmd_q.alu_op;
        exec_next.wsrc       = cmd_q.wsrc;
        exec_next.load_data  = cmd_q.load_data;
        exec_next.vd         = cmd_q.vd;
        exec_next.bwen       = cmd_q.bwen;
        exec_next.masked     = cmd_q.masked;
        exec_next.mask_idx   = cmd_q.mask_idx;
        exec_next.is_compare = (cmd_q.alu_op == lane_pkg::op_mseq) ||
                               (cmd_q.alu_op == lane_pkg::op_msltu);
        exec_next.valid      = cmd_valid_q;
    end

    //////////////////////////////////////////////////
    // Control delay so it meets read data at execute
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            exec_ctrl_o.valid <= 1'b0;
        end else begin
            exec_ctrl_o <= exec_next;
        end
    end

endmodule

// File: lane_execute.sv
// Execute stage with element extraction, operand selection and ALU feeding write-back
module lane_execute (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  lane_pkg::sew_e                  sew_i,
    input  logic [lane_pkg::word_w-1:0]     rdata_a_i,
    input  logic [lane_pkg::word_w-1:0]     rdata_b_i,
    input  lane_pkg::exec_ctrl_t            exec_ctrl_i,
    output lane_pkg::wb_ctrl_t              wb_ctrl_o
);

    lane_pkg::lane_word_u        word_a;
    lane_pkg::lane_word_u        word_b;
    logic [lane_pkg::word_w-1:0] elem_a;
    logic [lane_pkg::word_w-1:0] elem_b;
    logic [lane_pkg::word_w-1:0] op1;
    logic [lane_pkg::word_w-1:0] op2;
    logic [lane_pkg::word_w-1:0] alu_word;
    logic                        mask_bit;
    logic [lane_pkg::word_w-1:0] wr_data;
    lane_pkg::wb_ctrl_t          wb_next;

    // Zero-extended element picked by width and index
    function automatic logic [lane_pkg::word_w-1:0] extract_el(
        input lane_pkg::lane_word_u w,
        input lane_pkg::sew_e       sew,
        input logic [1:0]           idx
    );
        logic [lane_pkg::word_w-1:0] el;
        case (sew)
            lane_pkg::sew_byte: el = {{(lane_pkg::word_w - 8){1'b0}}, w.bytes[idx]};
            lane_pkg::sew_half: el = {{(lane_pkg::word_w - 16){1'b0}}, w.halves[idx[0]]};
            lane_pkg::sew_word: el = w;
            default:            el = '0;
        endcase
        return el;
    endfunction

    //////////////////////////////////////////////////
    // Operand preparation
    //////////////////////////////////////////////////
    assign word_a = rdata_a_i;
    assign word_b = rdata_b_i;
    assign elem_a = extract_el(word_a, sew_i, exec_ctrl_i.el_idx);
    assign elem_b = extract_el(word_b, sew_i, exec_ctrl_i.el_idx);
    assign op1    = elem_a;

    always_comb begin
        case (exec_ctrl_i.op2_sel)
            lane_pkg::op2_vector: op2 = elem_b;
            lane_pkg::op2_scalar: op2 = exec_ctrl_i.scalar;
            lane_pkg::op2_imm:    op2 = exec_ctrl_i.imm;
            default:              op2 = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        alu_word = '0;
        mask_bit = 1'b0;
        case (exec_ctrl_i.alu_op)
            lane_pkg::op_add:   alu_word = op1 + op2;
            lane_pkg::op_sub:   alu_word = op1 - op2;
            lane_pkg::op_and:   alu_word = op1 & op2;
            lane_pkg::op_or:    alu_word = op1 | op2;
            lane_pkg::op_xor:   alu_word = op1 ^ op2;
            // Shift amount from the low 5 bits only
            lane_pkg::op_sll:   alu_word = op1 << op2[4:0];
            lane_pkg::op_srl:   alu_word = op1 >> op2[4:0];
            lane_pkg::op_mseq:  mask_bit = (op1 == op2);
            lane_pkg::op_msltu: mask_bit = (op1 < op2);
            default:            alu_word = '0;
        endcase
    end

    // Compares report the mask bit in bit 0
    always_comb begin
        if (exec_ctrl_i.is_compare) begin
            wr_data = {{(lane_pkg::word_w - 1){1'b0}}, mask_bit};
        end else if (exec_ctrl_i.wsrc == lane_pkg::wsrc_load) begin
            wr_data = exec_ctrl_i.load_data;
        end else begin
            wr_data = alu_word;
        end
    end

    always_comb begin
        wb_next.valid      = exec_ctrl_i.valid;
        wb_next.vd         = exec_ctrl_i.vd;
        wb_next.bwen       = exec_ctrl_i.bwen;
        wb_next.masked     = exec_ctrl_i.masked;
        wb_next.mask_idx   = exec_ctrl_i.mask_idx;
        wb_next.is_compare = exec_ctrl_i.is_compare;
        wb_next.data       = wr_data;
    end

    // Registered at E2
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_ctrl_o.valid <= 1'b0;
        end else begin
            wb_ctrl_o <= wb_next;
        end
    end

endmodule

// File: lane_pkg.sv
// Vector lane package with sizes, opcode and selector types, stage structs and element view
package lane_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int vreg_addr_w  = 5;
    localparam int mask_addr_w  = 5;
    localparam int word_w       = 32;
    localparam int imm_w        = 5;
    // Edges from issue to result
    localparam int lane_latency = 4;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////
    // Element width, sew_none extracts zero
    typedef enum logic [1:0] {
        sew_byte = 2'd0,
        sew_half = 2'd1,
        sew_word = 2'd2,
        sew_none = 2'd3
    } sew_e;

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_mseq  = 4'd7,
        op_msltu = 4'd8
    } alu_op_e;

    // Second operand source, value 3 selects zero
    typedef enum logic [1:0] {
        op2_vector = 2'd0,
        op2_scalar = 2'd1,
        op2_imm    = 2'd2
    } op2_sel_e;

    typedef enum logic {
        wsrc_alu  = 1'b0,
        wsrc_load = 1'b1
    } wsrc_e;

    //////////////////////////////////////////////////
    // Stage structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [vreg_addr_w-1:0] vs1;
        logic [vreg_addr_w-1:0] vs2;
        logic [vreg_addr_w-1:0] vd;
        logic [1:0]             el_idx;
        op2_sel_e               op2_sel;
        logic [word_w-1:0]      scalar;
        logic [imm_w-1:0]       imm;
        alu_op_e                alu_op;
        wsrc_e                  wsrc;
        logic [word_w-1:0]      load_data;
        logic [word_w/8-1:0]    bwen;
        logic                   masked;
        logic [mask_addr_w-1:0] mask_idx;
    } lane_cmd_t;

    typedef struct packed {
        logic [1:0]             el_idx;
        op2_sel_e               op2_sel;
        logic [word_w-1:0]      scalar;
        logic [word_w-1:0]      imm;
        alu_op_e                alu_op;
        wsrc_e                  wsrc;
        logic [word_w-1:0]      load_data;
        logic [vreg_addr_w-1:0] vd;
        logic [word_w/8-1:0]    bwen;
        logic                   masked;
        logic [mask_addr_w-1:0] mask_idx;
        logic                   is_compare;
        logic                   valid;
    } exec_ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [vreg_addr_w-1:0] vd;
        logic [word_w/8-1:0]    bwen;
        logic                   masked;
        logic [mask_addr_w-1:0] mask_idx;
        logic                   is_compare;
        logic [word_w-1:0]      data;
    } wb_ctrl_t;

    // Write happens when any bwen bit is set
    typedef struct packed {
        logic [vreg_addr_w-1:0] addr;
        logic [word_w-1:0]      data;
        logic [word_w/8-1:0]    bwen;
    } vrf_wr_t;

    // One read word seen as bytes or halfwords
    typedef union packed {
        logic [word_w/8-1:0][7:0]   bytes;
        logic [word_w/16-1:0][15:0] halves;
    } lane_word_u;

endpackage

// File: lane_result.sv
// Result stage with mask register file, masked write-back and registered result outputs
module lane_result (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  lane_pkg::wb_ctrl_t              wb_ctrl_i,
    output lane_pkg::vrf_wr_t               vrf_wr_o,
    output logic                            result_valid_o,
    output logic [31:0]                     result_o
);

    localparam int mask_depth = 2 ** lane_pkg::mask_addr_w;

    logic [mask_depth-1:0] vmrf;
    logic                  vmrf_bit;
    logic                  vrf_wen;
    logic                  vmrf_wen;

    //////////////////////////////////////////////////
    // Write rules
    //////////////////////////////////////////////////
    assign vmrf_bit = vmrf[wb_ctrl_i.mask_idx];

    // Masked words only land where the mask bit is set
    assign vrf_wen  = wb_ctrl_i.valid && !wb_ctrl_i.is_compare &&
                      (!wb_ctrl_i.masked || vmrf_bit);
    assign vmrf_wen = wb_ctrl_i.valid && wb_ctrl_i.is_compare;

    assign vrf_wr_o.addr = wb_ctrl_i.vd;
    assign vrf_wr_o.data = wb_ctrl_i.data;
    assign vrf_wr_o.bwen = vrf_wen ? wb_ctrl_i.bwen : '0;

    //////////////////////////////////////////////////
    // Mask register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vmrf <= '0;
        end else if (vmrf_wen) begin
            vmrf[wb_ctrl_i.mask_idx] <= wb_ctrl_i.data[0];
        end
    end

    //////////////////////////////////////////////////
    // Result outputs, registered at E3
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= wb_ctrl_i.valid;
        end
        result_o <= wb_ctrl_i.data;
    end

endmodule

// File: lane_vrf.sv
// Vector register file with two synchronous read ports and one byte-enabled write port
module lane_vrf (
    input  logic                                  clk_i,
    input  logic [lane_pkg::vreg_addr_w-1:0]      raddr_a_i,
    input  logic [lane_pkg::vreg_addr_w-1:0]      raddr_b_i,
    input  lane_pkg::vrf_wr_t                     vrf_wr_i,
    output logic [lane_pkg::word_w-1:0]           rdata_a_o,
    output logic [lane_pkg::word_w-1:0]           rdata_b_o
);

    localparam int depth     = 2 ** lane_pkg::vreg_addr_w;
    localparam int num_bytes = lane_pkg::word_w / 8;

    // Storage kept as bytes for the per-byte write
    logic [num_bytes-1:0][7:0] mem [depth];

    //////////////////////////////////////////////////
    // Byte-enabled write
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < num_bytes; b++) begin
            if (vrf_wr_i.bwen[b]) begin
                mem[vrf_wr_i.addr][b] <= vrf_wr_i.data[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Synchronous reads
    //////////////////////////////////////////////////
    // Same-edge write to the read address returns old data
    always_ff @(posedge clk_i) begin
        rdata_a_o <= mem[raddr_a_i];
        rdata_b_o <= mem[raddr_b_i];
    end

endmodule

// File: sim.f
lane_pkg.sv
lane_decode.sv
lane_vrf.sv
lane_execute.sv
lane_result.sv
vector_lane.sv
tb_vector_lane_properties.sv
tb_vector_lane.sv

// File: tb_vector_lane.sv
// Directed testbench for the vector lane with reference model, random operands and watchdog
module tb_vector_lane;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int pipe_cmds    = 24;
    // Commands per test in run order
    localparam int total_cmds   = 16 + 25 + 10 + 12 + 21 + pipe_cmds;
    localparam int watchdog_cycles = total_cmds * (lane_pkg::lane_latency + 4) + 100;

    logic                clk_i;
    logic                rst_i;
    logic                cmd_valid_i;
    lane_pkg::lane_cmd_t cmd_i;
    lane_pkg::sew_e      sew_i;
    logic                result_valid_o;
    logic [31:0]         result_o;

    // Reference model of the register files
    logic [31:0] model_vrf [32];
    logic        model_vmrf [32];
    logic [31:0] rng_state;
    string       cur_test;
    int          error_count;
    int          test_errors_start;
    int          tests_passed;
    int          tests_failed;

    vector_lane vector_lane_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_i          (cmd_i),
        .sew_i          (sew_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles and the run did not finish", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", cur_test, expected, actual);
            error_count++;
        end
    endtask

    // Zero-extended element by width and index
    function automatic logic [31:0] element_of(input logic [31:0] w, input lane_pkg::sew_e sew,
                                               input logic [1:0] idx);
        logic [31:0] elem;
        case (sew)
            lane_pkg::sew_byte: elem = (w >> {idx, 3'b000}) & 32'h0000_00ff;
            lane_pkg::sew_half: elem = (w >> {idx[0], 4'b0000}) & 32'h0000_ffff;
            lane_pkg::sew_word: elem = w;
            default:            elem = 32'h0;
        endcase
        return elem;
    endfunction

    function automatic logic [31:0] expected_result(input lane_pkg::lane_cmd_t cmd,
                                                    input lane_pkg::sew_e sew);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] op2;
        logic [31:0] word;
        logic        flag;
        a    = element_of(model_vrf[cmd.vs1], sew, cmd.el_idx);
        b    = element_of(model_vrf[cmd.vs2], sew, cmd.el_idx);
        word = 32'h0;
        flag = 1'b0;
        case (cmd.op2_sel)
            lane_pkg::op2_vector: op2 = b;
            lane_pkg::op2_scalar: op2 = cmd.scalar;
            lane_pkg::op2_imm:    op2 = {27'd0, cmd.imm};
            default:              op2 = 32'h0;
        endcase
        case (cmd.alu_op)
            lane_pkg::op_add:   word = a + op2;
            lane_pkg::op_sub:   word = a - op2;
            lane_pkg::op_and:   word = a & op2;
            lane_pkg::op_or:    word = a | op2;
            lane_pkg::op_xor:   word = a ^ op2;
            lane_pkg::op_sll:   word = a << op2[4:0];
            lane_pkg::op_srl:   word = a >> op2[4:0];
            lane_pkg::op_mseq:  flag = (a == op2);
            lane_pkg::op_msltu: flag = (a < op2);
            default:            word = 32'h0;
        endcase
        if (cmd.alu_op == lane_pkg::op_mseq || cmd.alu_op == lane_pkg::op_msltu) begin
            return {31'd0, flag};
        end else if (cmd.wsrc == lane_pkg::wsrc_load) begin
            return cmd.load_data;
        end
        return word;
    endfunction

    // Compares write the mask, others write enabled bytes unless masked off
    function automatic void update_model(input lane_pkg::lane_cmd_t cmd, input logic [31:0] value);
        if (cmd.alu_op == lane_pkg::op_mseq || cmd.alu_op == lane_pkg::op_msltu) begin
            model_vmrf[cmd.mask_idx] = value[0];
        end else if (!cmd.masked || model_vmrf[cmd.mask_idx]) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd.bwen[b]) begin
                    model_vrf[cmd.vd][8*b +: 8] = value[8*b +: 8];
                end
            end
        end
    endfunction

    function automatic lane_pkg::lane_cmd_t base_cmd();
        lane_pkg::lane_cmd_t cmd;
        cmd          = '0;
        cmd.op2_sel  = lane_pkg::op2_imm;
        cmd.alu_op   = lane_pkg::op_add;
        cmd.wsrc     = lane_pkg::wsrc_alu;
        return cmd;
    endfunction

    function automatic lane_pkg::lane_cmd_t load_cmd(input logic [4:0] vd, input logic [31:0] data,
                                                     input logic [3:0] bwen);
        lane_pkg::lane_cmd_t cmd;
        cmd           = base_cmd();
        cmd.vd        = vd;
        cmd.wsrc      = lane_pkg::wsrc_load;
        cmd.load_data = data;
        cmd.bwen      = bwen;
        return cmd;
    endfunction

    // Add of immediate zero with no write-back
    function automatic lane_pkg::lane_cmd_t read_cmd(input logic [4:0] vs1, input logic [1:0] idx);
        lane_pkg::lane_cmd_t cmd;
        cmd        = base_cmd();
        cmd.vs1    = vs1;
        cmd.el_idx = idx;
        return cmd;
    endfunction

    function automatic lane_pkg::lane_cmd_t compare_cmd(input lane_pkg::alu_op_e op,
                                                        input logic [4:0] vs1, input logic [4:0] vs2,
                                                        input logic [4:0] mask_idx);
        lane_pkg::lane_cmd_t cmd;
        cmd          = base_cmd();
        cmd.alu_op   = op;
        cmd.vs1      = vs1;
        cmd.vs2      = vs2;
        cmd.op2_sel  = lane_pkg::op2_vector;
        cmd.vd       = 5'd17;
        cmd.bwen     = 4'hf;
        cmd.mask_idx = mask_idx;
        return cmd;
    endfunction

    // Reads from 0..15, writes to 16..31, compares set masks 8..15
    function automatic lane_pkg::lane_cmd_t random_cmd();
        lane_pkg::lane_cmd_t cmd;
        logic [31:0]         r;
        logic [31:0]         op;
        cmd           = base_cmd();
        r             = next_rand();
        op            = next_rand() % 32'd9;
        cmd.vs1       = {1'b0, r[3:0]};
        cmd.vs2       = {1'b0, r[7:4]};
        cmd.vd        = {1'b1, r[11:8]};
        cmd.op2_sel   = lane_pkg::op2_sel_e'(r[13:12]);
        cmd.imm       = r[18:14];
        cmd.wsrc      = lane_pkg::wsrc_e'(r[19]);
        cmd.bwen      = r[23:20];
        cmd.masked    = r[24];
        cmd.mask_idx  = {1'b0, r[28:25]};
        cmd.el_idx    = r[30:29];
        cmd.alu_op    = lane_pkg::alu_op_e'(op[3:0]);
        cmd.scalar    = next_rand();
        cmd.load_data = next_rand();
        if (cmd.alu_op == lane_pkg::op_mseq || cmd.alu_op == lane_pkg::op_msltu) begin
            cmd.mask_idx = {2'b01, r[27:25]};
        end
        return cmd;
    endfunction

    // Issue one command and wait for its result
    task automatic run_cmd(input lane_pkg::lane_cmd_t cmd, input lane_pkg::sew_e sew);
        logic [31:0] expected;
        int          cycles;
        expected = expected_result(cmd, sew);
        update_model(cmd, expected);
        @(negedge clk_i);
        cmd_i       = cmd;
        sew_i       = sew;
        cmd_valid_i = 1'b1;
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
        cycles      = 1;
        while (!result_valid_o && cycles < lane_pkg::lane_latency) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!result_valid_o) begin
            $display("error in %s: no result within %0d cycles of issue", cur_test,
                     lane_pkg::lane_latency);
            error_count++;
        end else if (cycles != lane_pkg::lane_latency) begin
            $display("error in %s: result came %0d cycles after issue instead of %0d",
                     cur_test, cycles, lane_pkg::lane_latency);
            error_count++;
        end else begin
            check_value(expected, result_o);
        end
    endtask

    task automatic start_test(input string name);
        cur_test          = name;
        test_errors_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == test_errors_start) begin
            $display("test %s passed", cur_test);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", cur_test, error_count - test_errors_start);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic load_and_read_back();
        start_test("load_and_read_back");
        for (int r = 0; r < 8; r++) begin
            run_cmd(load_cmd(r[4:0], next_rand(), 4'hf), lane_pkg::sew_word);
        end
        for (int r = 0; r < 8; r++) begin
            run_cmd(read_cmd(r[4:0], 2'd0), lane_pkg::sew_word);
        end
        end_test();
    endtask

    task automatic alu_operations();
        lane_pkg::lane_cmd_t cmd;
        logic [31:0]         rnd;
        start_test("alu_operations");
        for (int r = 8; r < 12; r++) begin
            run_cmd(load_cmd(r[4:0], next_rand(), 4'hf), lane_pkg::sew_word);
        end
        // Every word opcode against each operand source
        for (int op = 0; op < 7; op++) begin
            for (int sel = 0; sel < 3; sel++) begin
                rnd         = next_rand();
                cmd         = base_cmd();
                cmd.vs1     = {3'b010, rnd[1:0]};
                cmd.vs2     = {3'b010, rnd[3:2]};
                cmd.imm     = rnd[8:4];
                cmd.scalar  = next_rand();
                cmd.op2_sel = lane_pkg::op2_sel_e'(sel[1:0]);
                cmd.alu_op  = lane_pkg::alu_op_e'(op[3:0]);
                cmd.vd      = 5'd25;
                cmd.bwen    = 4'hf;
                run_cmd(cmd, lane_pkg::sew_word);
            end
        end
        end_test();
    endtask

    task automatic element_extraction();
        start_test("element_extraction");
        run_cmd(load_cmd(5'd12, next_rand(), 4'hf), lane_pkg::sew_word);
        for (int i = 0; i < 4; i++) begin
            run_cmd(read_cmd(5'd12, i[1:0]), lane_pkg::sew_byte);
        end
        for (int i = 0; i < 4; i++) begin
            run_cmd(read_cmd(5'd12, i[1:0]), lane_pkg::sew_half);
        end
        run_cmd(read_cmd(5'd12, 2'd0), lane_pkg::sew_none);
        end_test();
    endtask

    task automatic partial_writes();
        logic [3:0] patterns [4] = '{4'b0001, 4'b0110, 4'b1010, 4'b1100};
        start_test("partial_writes");
        for (int i = 0; i < 4; i++) begin
            run_cmd(load_cmd(5'd13 + i[4:0], next_rand(), 4'hf), lane_pkg::sew_word);
            run_cmd(load_cmd(5'd13 + i[4:0], next_rand(), patterns[i]), lane_pkg::sew_word);
            run_cmd(read_cmd(5'd13 + i[4:0], 2'd0), lane_pkg::sew_word);
        end
        end_test();
    endtask

    task automatic compares_and_masks();
        lane_pkg::lane_cmd_t cmd;
        logic [31:0]         base;
        start_test("compares_and_masks");
        base = next_rand() & 32'h7fff_ffff;
        run_cmd(load_cmd(5'd17, base, 4'hf), lane_pkg::sew_word);
        run_cmd(load_cmd(5'd18, base, 4'hf), lane_pkg::sew_word);
        run_cmd(load_cmd(5'd19, base + 32'd1, 4'hf), lane_pkg::sew_word);
        // Mask 2 set then cleared
        run_cmd(compare_cmd(lane_pkg::op_mseq, 5'd17, 5'd18, 5'd2), lane_pkg::sew_word);
        run_cmd(compare_cmd(lane_pkg::op_mseq, 5'd17, 5'd19, 5'd2), lane_pkg::sew_word);
        run_cmd(compare_cmd(lane_pkg::op_mseq, 5'd17, 5'd18, 5'd1), lane_pkg::sew_word);
        run_cmd(compare_cmd(lane_pkg::op_msltu, 5'd17, 5'd19, 5'd3), lane_pkg::sew_word);
        run_cmd(compare_cmd(lane_pkg::op_msltu, 5'd19, 5'd17, 5'd4), lane_pkg::sew_word);
        for (int i = 0; i < 4; i++) begin
            run_cmd(load_cmd(5'd21 + i[4:0], next_rand(), 4'hf), lane_pkg::sew_word);
        end
        for (int i = 0; i < 4; i++) begin
            cmd          = load_cmd(5'd21 + i[4:0], next_rand(), 4'hf);
            cmd.masked   = 1'b1;
            cmd.mask_idx = 5'd1 + i[4:0];
            run_cmd(cmd, lane_pkg::sew_word);
        end
        for (int i = 0; i < 4; i++) begin
            run_cmd(read_cmd(5'd21 + i[4:0], 2'd0), lane_pkg::sew_word);
        end
        // Compares must leave their vd untouched
        run_cmd(read_cmd(5'd17, 2'd0), lane_pkg::sew_word);
        end_test();
    endtask

    task automatic pipelined_throughput();
        lane_pkg::lane_cmd_t cmd;
        logic [31:0]         exp_q [$];
        int                  issue_q [$];
        logic [31:0]         exp_val;
        int                  issue_step;
        int                  issued;
        start_test("pipelined_throughput");
        issued = 0;
        for (int step = 0; step < pipe_cmds + lane_pkg::lane_latency + 4; step++) begin
            @(negedge clk_i);
            if (result_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("error in %s: result with no command outstanding", cur_test);
                    error_count++;
                end else begin
                    exp_val    = exp_q.pop_front();
                    issue_step = issue_q.pop_front();
                    if (step - issue_step != lane_pkg::lane_latency) begin
                        $display("error in %s: result came %0d cycles after issue", cur_test,
                                 step - issue_step);
                        error_count++;
                    end
                    check_value(exp_val, result_o);
                end
            end
            if (issued < pipe_cmds) begin
                cmd     = random_cmd();
                exp_val = expected_result(cmd, lane_pkg::sew_word);
                update_model(cmd, exp_val);
                exp_q.push_back(exp_val);
                issue_q.push_back(step);
                cmd_i       = cmd;
                sew_i       = lane_pkg::sew_word;
                cmd_valid_i = 1'b1;
                issued++;
            end else begin
                cmd_valid_i = 1'b0;
            end
        end
        if (exp_q.size() != 0) begin
            $display("error in %s: %0d results never arrived", cur_test, exp_q.size());
            error_count++;
        end
        end_test();
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_i        = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        sew_i        = lane_pkg::sew_word;
        rng_state    = 32'h9d50_363f;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            model_vrf[i]  = 32'h0;
            model_vmrf[i] = 1'b0;
        end
        repeat (reset_cycles) @(negedge clk_i);
        rst_i = 1'b1;
        load_and_read_back();
        alu_operations();
        element_extraction();
        partial_writes();
        compares_and_masks();
        pipelined_throughput();
        $display("tests passed %0d failed %0d with %0d errors", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb_vector_lane_properties.sv
// Bound assertions on lane pipeline timing, register file write enables and reset behavior
module tb_vector_lane_properties (
    input logic              clk_i,
    input logic              rst_i,
    input logic              cmd_valid_i,
    input logic              result_valid_i,
    input lane_pkg::vrf_wr_t vrf_wr_i
);

    //////////////////////////////////////////////////
    // Pipeline timing
    //////////////////////////////////////////////////
    result_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        result_valid_i == $past(cmd_valid_i, lane_pkg::lane_latency))
        else $error("result valid does not trail command valid by the lane latency");

    // Byte enables only for a command issued at the matching earlier edge
    write_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
        (vrf_wr_i.bwen != '0) |-> $past(cmd_valid_i, lane_pkg::lane_latency - 1))
        else $error("register file byte enable set without a valid command in the write stage");

    reset_clears_result: assert property (@(posedge clk_i)
        !rst_i |=> !result_valid_i)
        else $error("result valid high while reset is applied");

endmodule

bind vector_lane tb_vector_lane_properties vector_lane_props_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_valid_i    (cmd_valid_i),
    .result_valid_i (result_valid_o),
    .vrf_wr_i       (vrf_wr)
);

// File: vector_lane.sv
// Vector lane top level connecting decode, register file, execute and result stages
module vector_lane (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  lane_pkg::lane_cmd_t cmd_i,
    input  lane_pkg::sew_e      sew_i,
    output logic                result_valid_o,
    output logic [31:0]         result_o
);

    //////////////////////////////////////////////////
    // Stage interconnect
    //////////////////////////////////////////////////
    logic [lane_pkg::vreg_addr_w-1:0] raddr_a;
    logic [lane_pkg::vreg_addr_w-1:0] raddr_b;
    logic [lane_pkg::word_w-1:0]      rdata_a;
    logic [lane_pkg::word_w-1:0]      rdata_b;
    lane_pkg::exec_ctrl_t             exec_ctrl;
    lane_pkg::wb_ctrl_t               wb_ctrl;
    lane_pkg::vrf_wr_t                vrf_wr;

    lane_decode lane_decode_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .raddr_a_o   (raddr_a),
        .raddr_b_o   (raddr_b),
        .exec_ctrl_o (exec_ctrl)
    );

    lane_vrf lane_vrf_inst (
        .clk_i     (clk_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .vrf_wr_i  (vrf_wr),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    lane_execute lane_execute_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sew_i       (sew_i),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .exec_ctrl_i (exec_ctrl),
        .wb_ctrl_o   (wb_ctrl)
    );

    // Write-back loops back into the register file
    lane_result lane_result_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wb_ctrl_i      (wb_ctrl),
        .vrf_wr_o       (vrf_wr),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule
